//--- hw/jpeg_bits_pkg.sv
`default_nettype none

package jpeg_bits_pkg;

	localparam int WORD_BITS = 32; // Output word and fragment data width
	localparam int LEN_BITS = 6;   // Holds 1 to 32
	localparam int FILL_BITS = 6;  // Holds 0 to 63

	// Code bits, first bit in the MSB
	typedef logic [WORD_BITS-1:0] code_word_t;

	// Number of valid bits in a fragment
	typedef logic [LEN_BITS-1:0] bit_len_t;

	// Pending bits in the packer accumulator
	typedef logic [FILL_BITS-1:0] bit_count_t;

	// One variable-length code fragment, left-justified
	typedef struct packed
	{
		code_word_t data;
		bit_len_t len;
		logic eob; // Last fragment of the block
	} frag_t;

endpackage

`default_nettype wire

//--- hw/jpeg_comp_pkg.sv
`default_nettype none

package jpeg_comp_pkg;

	// Color component, also the sequencer state
	typedef enum logic [1:0]
	{
		COMP_Y = 2'd0,
		COMP_CB = 2'd1,
		COMP_CR = 2'd2
	} comp_t;

	// Y blocks seen within the current MCU
	typedef logic [2:0] blk_count_t;

endpackage

`default_nettype wire

//--- hw/frag_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module frag_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input jpeg_bits_pkg::frag_t in_frag,
	input logic in_valid,
	output logic in_ready,
	output jpeg_bits_pkg::frag_t out_frag,
	output logic out_valid,
	input logic pop
);

	import jpeg_bits_pkg::*;

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);
	localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(FIFO_DEPTH);

	frag_t mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] count;
	logic push;
	logic do_pop;

	assign in_ready = (count != FULL_COUNT);
	assign out_valid = (count != '0);
	assign out_frag = mem[rd_ptr]; // Show-ahead head entry

	assign push = in_valid && in_ready;
	assign do_pop = pop && out_valid;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_frag;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/comp_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module comp_sequencer #(
	parameter int Y_BLOCKS_PER_MCU = 1
) (
	input logic clk,
	input logic rst,
	input jpeg_bits_pkg::frag_t y_frag,
	input jpeg_bits_pkg::frag_t cb_frag,
	input jpeg_bits_pkg::frag_t cr_frag,
	input logic y_valid,
	input logic cb_valid,
	input logic cr_valid,
	output logic y_pop,
	output logic cb_pop,
	output logic cr_pop,
	output jpeg_bits_pkg::frag_t frag,
	output logic frag_valid,
	input logic frag_ready
);

	import jpeg_comp_pkg::*;

	localparam blk_count_t LAST_Y = blk_count_t'(Y_BLOCKS_PER_MCU - 1);

	comp_t state;
	comp_t state_next;
	blk_count_t y_count;
	logic xfer;
	logic block_done;

	// Only the current component reaches the packer
	always_comb
	begin
		frag = y_frag;
		frag_valid = y_valid;
		case (state)
			COMP_CB:
			begin
				frag = cb_frag;
				frag_valid = cb_valid;
			end
			COMP_CR:
			begin
				frag = cr_frag;
				frag_valid = cr_valid;
			end
			default:
			begin
				frag = y_frag;
				frag_valid = y_valid;
			end
		endcase
	end

	assign xfer = frag_valid && frag_ready;
	assign block_done = xfer && frag.eob;

	assign y_pop = xfer && (state == COMP_Y);
	assign cb_pop = xfer && (state == COMP_CB);
	assign cr_pop = xfer && (state == COMP_CR);

	always_comb
	begin
		case (state)
			COMP_Y: state_next = (y_count == LAST_Y) ? COMP_CB : COMP_Y;
			COMP_CB: state_next = COMP_CR;
			default: state_next = COMP_Y; // Cr closes the MCU
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= COMP_Y;
			y_count <= '0;
		end
		else if (block_done)
		begin
			state <= state_next;
			if (state == COMP_Y)
				y_count <= (y_count == LAST_Y) ? '0 : y_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/bit_packer.sv
`timescale 1ns/100ps
`default_nettype none

module bit_packer (
	input logic clk,
	input logic rst,
	input jpeg_bits_pkg::frag_t frag,
	input logic frag_valid,
	output logic frag_ready,
	output jpeg_bits_pkg::code_word_t word,
	output logic word_valid,
	input logic word_ready,
	output jpeg_bits_pkg::bit_count_t fill
);

	import jpeg_bits_pkg::*;

	localparam int ACC_BITS = 2 * WORD_BITS;
	localparam bit_count_t FULL_WORD = bit_count_t'(WORD_BITS);

	logic [ACC_BITS-1:0] acc;       // Pending bits, MSB-aligned
	logic [ACC_BITS-1:0] keep_mask;
	logic [ACC_BITS-1:0] frag_bits;
	code_word_t data_mask;
	logic take_frag;
	logic take_word;

	// Fragments only while less than a word is pending
	assign frag_ready = (fill < FULL_WORD);
	assign word_valid = !frag_ready;
	assign word = acc[ACC_BITS-1 -: WORD_BITS];

	assign take_frag = frag_valid && frag_ready;
	assign take_word = word_valid && word_ready;

	// Top len bits of the fragment
	assign data_mask = ~({WORD_BITS{1'b1}} >> frag.len);

	// Bits below the fill are dropped, new bits land right under it
	assign keep_mask = ~({ACC_BITS{1'b1}} >> fill);
	assign frag_bits = {frag.data & data_mask, {WORD_BITS{1'b0}}} >> fill;

	always_ff @(posedge clk)
	begin
		if (take_word)
			acc <= acc << WORD_BITS;
		else if (take_frag)
			acc <= (acc & keep_mask) | frag_bits;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			fill <= '0;
		else if (take_word)
			fill <= fill - FULL_WORD; // Leftover carries into the next word
		else if (take_frag)
			fill <= fill + frag.len;
	end

endmodule

`default_nettype wire

//--- hw/word_out_buf.sv
`timescale 1ns/100ps
`default_nettype none

module word_out_buf (
	input logic clk,
	input logic rst,
	input jpeg_bits_pkg::code_word_t in_word,
	input logic in_valid,
	output logic in_ready,
	output jpeg_bits_pkg::code_word_t out_word,
	output logic out_valid,
	input logic out_ready
);

	import jpeg_bits_pkg::*;

	code_word_t skid_word; // Holds a word while in_ready is low
	logic load_main;
	logic load_skid;

	assign load_main = in_ready ? (in_valid && (!out_valid || out_ready)) : out_ready;
	assign load_skid = in_ready && in_valid && out_valid && !out_ready;

	always_ff @(posedge clk)
	begin
		if (load_main)
			out_word <= in_ready ? in_word : skid_word;
		if (load_skid)
			skid_word <= in_word;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			in_ready <= 1'b1;
		end
		else if (in_ready)
		begin
			if (!out_valid || out_ready)
				out_valid <= in_valid;
			else if (in_valid)
				in_ready <= 1'b0; // Second entry now taken
		end
		else if (out_ready)
			in_ready <= 1'b1; // Skid word moves to the output
	end

endmodule

`default_nettype wire

//--- hw/jpeg_stream_merge.sv
`timescale 1ns/100ps
`default_nettype none

module jpeg_stream_merge #(
	parameter int FIFO_DEPTH = 8,
	parameter int Y_BLOCKS_PER_MCU = 1
) (
	input logic clk,
	input logic rst,
	input jpeg_bits_pkg::frag_t y_in,
	input jpeg_bits_pkg::frag_t cb_in,
	input jpeg_bits_pkg::frag_t cr_in,
	input logic y_valid,
	input logic cb_valid,
	input logic cr_valid,
	output logic y_ready,
	output logic cb_ready,
	output logic cr_ready,
	output jpeg_bits_pkg::code_word_t out_word,
	output logic out_valid,
	input logic out_ready,
	output jpeg_bits_pkg::bit_count_t fill_level
);

	import jpeg_bits_pkg::*;

	frag_t y_head;
	frag_t cb_head;
	frag_t cr_head;
	logic y_head_valid;
	logic cb_head_valid;
	logic cr_head_valid;
	logic y_pop;
	logic cb_pop;
	logic cr_pop;
	frag_t seq_frag;
	logic seq_valid;
	logic seq_ready;
	code_word_t pack_word;
	logic pack_valid;
	logic pack_ready;

	frag_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) y_fifo_i (
		.clk(clk), .rst(rst),
		.in_frag(y_in), .in_valid(y_valid), .in_ready(y_ready),
		.out_frag(y_head), .out_valid(y_head_valid), .pop(y_pop)
	);

	frag_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cb_fifo_i (
		.clk(clk), .rst(rst),
		.in_frag(cb_in), .in_valid(cb_valid), .in_ready(cb_ready),
		.out_frag(cb_head), .out_valid(cb_head_valid), .pop(cb_pop)
	);

	frag_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cr_fifo_i (
		.clk(clk), .rst(rst),
		.in_frag(cr_in), .in_valid(cr_valid), .in_ready(cr_ready),
		.out_frag(cr_head), .out_valid(cr_head_valid), .pop(cr_pop)
	);

	comp_sequencer #(.Y_BLOCKS_PER_MCU(Y_BLOCKS_PER_MCU)) comp_sequencer_i (
		.clk(clk), .rst(rst),
		.y_frag(y_head), .cb_frag(cb_head), .cr_frag(cr_head),
		.y_valid(y_head_valid), .cb_valid(cb_head_valid), .cr_valid(cr_head_valid),
		.y_pop(y_pop), .cb_pop(cb_pop), .cr_pop(cr_pop),
		.frag(seq_frag), .frag_valid(seq_valid), .frag_ready(seq_ready)
	);

	bit_packer bit_packer_i (
		.clk(clk), .rst(rst),
		.frag(seq_frag), .frag_valid(seq_valid), .frag_ready(seq_ready),
		.word(pack_word), .word_valid(pack_valid), .word_ready(pack_ready),
		.fill(fill_level)
	);

	word_out_buf word_out_buf_i (
		.clk(clk), .rst(rst),
		.in_word(pack_word), .in_valid(pack_valid), .in_ready(pack_ready),
		.out_word(out_word), .out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0; // Released on a rising edge
	end

endmodule

`default_nettype wire

//--- dv/jpeg_stream_merge_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module jpeg_stream_merge_asserts (
	input logic clk,
	input logic rst,
	input jpeg_bits_pkg::code_word_t out_word,
	input logic out_valid,
	input logic out_ready,
	input jpeg_bits_pkg::bit_count_t fill_level,
	input logic y_ready,
	input logic cb_ready,
	input logic cr_ready
);

	import jpeg_bits_pkg::*;

	localparam bit_count_t FULL_WORD = bit_count_t'(WORD_BITS);

	int stall_fails = 0;
	int ready_fails = 0;
	int unknown_fails = 0;
	int fail_count;

	assign fail_count = stall_fails + ready_fails + unknown_fails;

	// Word held until taken
	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_word))
	else
	begin
		stall_fails++;
		$error("out_word or out_valid changed during a stall");
	end

	// Fill only holds or drops by a word
	assert property (@(posedge clk) disable iff (rst)
		fill_level >= FULL_WORD |=> fill_level == $past(fill_level)
			|| fill_level == $past(fill_level) - FULL_WORD)
	else
	begin
		ready_fails++;
		$error("packer took a fragment with a full word pending");
	end

	assert property (@(posedge clk) disable iff (rst)
		!$isunknown({y_ready, cb_ready, cr_ready}))
	else
	begin
		unknown_fails++;
		$error("input ready is unknown");
	end

endmodule

`default_nettype wire

//--- dv/jpeg_stream_merge_tb.sv
`timescale 1ns/100ps
`default_nettype none

module jpeg_stream_merge_tb;

	import jpeg_bits_pkg::*;
	import jpeg_comp_pkg::*;

	localparam int WAIT_LIMIT = 2000; // Cycles per wait loop

	logic clk;
	logic rst;
	frag_t drv_frag [3]; // Indexed by comp_t
	logic [2:0] drv_valid;
	wire [2:0] in_ready;
	code_word_t out_word;
	logic out_valid;
	logic out_ready;
	bit_count_t fill_level;

	frag_t frag_q [3][$];
	code_word_t exp_q [$];
	int error_count = 0;
	int check_count = 0;
	int word_count = 0;
	int test_count = 0;
	int total_bits = 0;
	logic timed_out = 1'b0;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) tb_clock_gen_i (.clk(clk), .rst(rst));

	jpeg_stream_merge #(.FIFO_DEPTH(4), .Y_BLOCKS_PER_MCU(2)) jpeg_stream_merge_i (
		.clk(clk), .rst(rst),
		.y_in(drv_frag[0]), .cb_in(drv_frag[1]), .cr_in(drv_frag[2]),
		.y_valid(drv_valid[0]), .cb_valid(drv_valid[1]), .cr_valid(drv_valid[2]),
		.y_ready(in_ready[0]), .cb_ready(in_ready[1]), .cr_ready(in_ready[2]),
		.out_word(out_word), .out_valid(out_valid), .out_ready(out_ready),
		.fill_level(fill_level)
	);

	bind jpeg_stream_merge jpeg_stream_merge_asserts asserts_i (
		.clk(clk), .rst(rst), .out_word(out_word), .out_valid(out_valid),
		.out_ready(out_ready), .fill_level(fill_level),
		.y_ready(y_ready), .cb_ready(cb_ready), .cr_ready(cr_ready)
	);

	task automatic check_word(input string name, input code_word_t got, input code_word_t exp);
		check_count++;
		if (got !== exp)
		begin
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_fill(input string name, input bit_count_t got, input bit_count_t exp);
		check_count++;
		if (got !== exp)
		begin
			$display("ERROR %0t %s: got %0d, expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp)
		begin
			$display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		error_count++;
		timed_out = 1'b1;
	endtask

	task automatic drive_comp(input comp_t comp);
		frag_t f;
		int gap;
		int waited;
		gap = (comp == COMP_Y) ? 6 : ((comp == COMP_CB) ? 3 : 0); // Cr shows up first
		repeat (gap) @(posedge clk);
		while (frag_q[comp].size() > 0 && !timed_out)
		begin
			f = frag_q[comp].pop_front();
			gap = $urandom % 3;
			@(posedge clk);
			if (gap > 0)
			begin
				drv_valid[comp] <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			drv_frag[comp] <= f;
			drv_valid[comp] <= 1'b1;
			waited = 0;
			@(negedge clk);
			while (!in_ready[comp] && waited < WAIT_LIMIT)
			begin
				@(negedge clk);
				waited++;
			end
			if (waited == WAIT_LIMIT)
				report_timeout("input ready");
		end
		@(posedge clk);
		drv_valid[comp] <= 1'b0;
	endtask

	task automatic run_test(input bit_count_t file_fill);
		int waited;
		fork
			drive_comp(COMP_Y);
			drive_comp(COMP_CB);
			drive_comp(COMP_CR);
		join
		waited = 0;
		@(negedge clk);
		while ((exp_q.size() != 0 || jpeg_stream_merge_i.y_head_valid
			|| jpeg_stream_merge_i.cb_head_valid || jpeg_stream_merge_i.cr_head_valid)
			&& waited < WAIT_LIMIT && !timed_out)
		begin
			@(negedge clk);
			waited++;
		end
		if (waited == WAIT_LIMIT)
			report_timeout("output words and FIFO drain");
		else if (!timed_out)
		begin
			@(posedge clk);
			@(negedge clk); // Last word has left the buffer
			check_fill("fill_level", fill_level, file_fill);
			check_fill("fill_level", fill_level, bit_count_t'(total_bits % WORD_BITS));
			check_flag("out_valid", out_valid, 1'b0);
			test_count++;
		end
	endtask

	// Output back-pressure
	initial
	begin
		forever
		begin
			@(posedge clk);
			out_ready <= ($urandom % 4) != 0;
		end
	end

	always @(negedge clk)
	begin
		if (!rst && out_valid && out_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected extra output word %h at %0t", out_word, $time);
				error_count++;
			end
			else
				check_word("out_word", out_word, exp_q.pop_front());
			word_count++;
		end
	end

	initial
	begin
		int fd;
		int waited;
		int comp_i;
		int len_i;
		int eob_i;
		int fill_i;
		code_word_t data_w;
		string line;
		frag_t f;

		void'($urandom(32'h17ec));
		foreach (drv_frag[i])
			drv_frag[i] = '0;
		drv_valid = '0;
		out_ready = 1'b0;

		waited = 0;
		@(posedge clk);
		@(negedge clk);
		while (rst && waited < WAIT_LIMIT)
		begin
			check_flag("out_valid", out_valid, 1'b0);
			check_fill("fill_level", fill_level, '0);
			@(negedge clk);
			waited++;
		end
		if (waited == WAIT_LIMIT)
			report_timeout("reset release");
		check_flag("out_valid", out_valid, 1'b0);
		check_fill("fill_level", fill_level, '0);
		check_flag("y_ready", in_ready[0], 1'b1);
		check_flag("cb_ready", in_ready[1], 1'b1);
		check_flag("cr_ready", in_ready[2], 1'b1);

		fd = $fopen("dv/merge_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the test data file dv/merge_tests.txt");
			error_count++;
		end
		else
		begin
			while (!timed_out && $fgets(line, fd) != 0)
			begin
				if (line.getc(0) == "F")
				begin
					void'($sscanf(line, "F %d %d %h %d", comp_i, len_i, data_w, eob_i));
					f.data = data_w;
					f.len = bit_len_t'(len_i);
					f.eob = eob_i[0];
					frag_q[comp_i].push_back(f);
					total_bits += len_i;
				end
				else if (line.getc(0) == "W")
				begin
					void'($sscanf(line, "W %h", data_w));
					exp_q.push_back(data_w);
				end
				else if (line.getc(0) == "E")
				begin
					void'($sscanf(line, "E %d", fill_i));
					run_test(bit_count_t'(fill_i));
				end
			end
			$fclose(fd);
		end
		if (test_count == 0)
		begin
			$display("No test was completed");
			error_count++;
		end

		error_count += jpeg_stream_merge_i.asserts_i.fail_count;
		$display("Tests: %0d, words: %0d, checks: %0d, errors: %0d",
			test_count, word_count, check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/merge_tests.txt
# F comp len data eob: fragment, comp 0=Y 1=Cb 2=Cr, len decimal, data hex left-justified
# W word: next expected output word in hex; E fill: expected fill after the test drains
# Test 1: 32-bit fragments, a Y block boundary inside a word, masked low bits
F 0 32 DEADBEEF 0
F 0 12 ABCFFFFF 1
F 0 20 12345000 1
F 1 32 CAFEF00D 1
F 2 8 5A000000 0
F 2 24 C3C3C3AA 1
W DEADBEEF
W ABC12345
W CAFEF00D
W 5AC3C3C3
E 0
# Test 2: runs of 1-bit fragments across word and block boundaries, bits left over
F 0 28 12345670 0
F 0 1 80000000 0
F 0 1 7FFFFFFF 0
F 0 1 80000000 0
F 0 1 FFFFFFFF 0
F 0 1 00000000 0
F 0 1 80000000 1
F 0 1 80000000 0
F 0 32 0F0F0F0F 1
F 1 1 00000000 0
F 1 1 7FFFFFFF 0
F 1 1 80000000 1
F 2 16 A5A5FFFF 0
F 2 1 80000000 0
F 2 16 F00F1234 1
W 1234567B
W 61E1E1E1
W E69697E0
E 7

//--- flist.f
hw/jpeg_bits_pkg.sv
hw/jpeg_comp_pkg.sv
hw/frag_fifo.sv
hw/comp_sequencer.sv
hw/bit_packer.sv
hw/word_out_buf.sv
hw/jpeg_stream_merge.sv
dv/tb_clock_gen.sv
dv/jpeg_stream_merge_asserts.sv
dv/jpeg_stream_merge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module jpeg_stream_merge_tb \
	-f flist.f \
	-o sim_merge

./obj_dir/sim_merge +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation passed" sim.log
then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
